//--- Bender.yml
package:
  name: tpu_compute

export_include_dirs:
  - source

sources:
  - files:
      - source/tpu_pkg.sv
      - source/weight_loader.sv
      - source/compute_control_unit.sv
      - source/activation_skew.sv
      - source/mac_array.sv
      - source/tpu_compute_top.sv
  - target: test
    files:
      - verif/tpu_compute_tb.sv

//--- compile.f
+incdir+source
source/tpu_pkg.sv
source/weight_loader.sv
source/compute_control_unit.sv
source/activation_skew.sv
source/mac_array.sv
source/tpu_compute_top.sv
verif/tpu_compute_tb.sv

//--- source/activation_skew.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module activation_skew
    import tpu_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire tpu_ctrl_t ctrl_i,
    input  wire tpu_vec_t  act_row_i,
    output tpu_vec_t       skewed_o
);

    localparam int N = `TPU_MUL_SIZE;
    localparam int DW = `TPU_DATA_W;

    logic     en_q;
    tpu_vec_t gated;

    // row data arrives one cycle after the request
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            en_q <= 1'b0;
        end else begin
            en_q <= ctrl_i.mac_en;
        end
    end

    // bubbles become zeros
    assign gated = en_q ? act_row_i : '0;

    assign skewed_o.lane[0] = gated.lane[0];

    for (genvar k = 1; k < N; k++) begin : g_lane
        logic [k-1:0][DW-1:0] pipe_q;

        always_ff @(posedge clk_i or negedge rst_n_i) begin
            if (!rst_n_i) begin
                pipe_q <= '0;
            end else begin
                pipe_q[0] <= gated.lane[k];
                for (int j = 1; j < k; j++) begin
                    pipe_q[j] <= pipe_q[j-1];
                end
            end
        end

        assign skewed_o.lane[k] = pipe_q[k-1];
    end

endmodule

`default_nettype wire

//--- source/compute_control_unit.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module compute_control_unit
    import tpu_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        instr_valid_i,
    input  wire tpu_instr_u  instr_i,
    input  wire logic        weights_rdy_i,
    output tpu_ctrl_t        ctrl_o,
    output logic             weights_taken_o,
    output logic             stall_o
);

    typedef enum logic [1:0] {
        st_stall,
        st_load_act,
        st_compute,
        st_return
    } cu_state_e;

    cu_state_e              state_q;
    logic [`TPU_ROWS_W-1:0] compute_cntr_q;
    logic [`TPU_ROWS_W-1:0] rows_q;
    logic [`TPU_ROWS_W-1:0] pend_rows_q;
    logic                   pend_q;

    logic                   new_cmd;
    logic                   pend_any;
    logic [`TPU_ROWS_W-1:0] pend_rows;
    logic                   go;
    logic                   last_wait;
    logic                   last_row;

    assign new_cmd   = instr_valid_i && (instr_i.cmp.op == op_compute);
    // an instruction arriving this cycle counts as pending already
    assign pend_any  = pend_q || new_cmd;
    assign pend_rows = new_cmd ? instr_i.cmp.rows : pend_rows_q;
    assign go        = (state_q == st_stall) && pend_any && weights_rdy_i;

    assign last_wait = (state_q == st_load_act) &&
                       (compute_cntr_q == `TPU_ROWS_W'(`TPU_ACT_WAIT - 1));
    assign last_row  = (state_q == st_compute) && (compute_cntr_q == rows_q - 1'b1);

    always_comb begin
        ctrl_o           = '0;
        ctrl_o.act_req   = (state_q == st_compute);
        ctrl_o.mac_en    = (state_q == st_compute);
        // swap on the final activation load cycle
        ctrl_o.swap_bank = last_wait;
    end

    assign weights_taken_o = last_wait;
    assign stall_o         = (state_q == st_stall);

    // pending compute command
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            pend_q      <= 1'b0;
            pend_rows_q <= '0;
        end else if (go) begin
            pend_q <= 1'b0;
        end else if (new_cmd) begin
            pend_q      <= 1'b1;
            pend_rows_q <= instr_i.cmp.rows;
        end
    end

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            state_q        <= st_stall;
            compute_cntr_q <= '0;
            rows_q         <= '0;
        end else begin
            case (state_q)
                st_stall: begin
                    if (go) begin
                        state_q        <= st_load_act;
                        compute_cntr_q <= '0;
                        rows_q         <= pend_rows;
                    end
                end
                st_load_act: begin
                    if (last_wait) begin
                        compute_cntr_q <= '0;
                        // zero rows means there is nothing to stream
                        state_q <= (rows_q == '0) ? st_return : st_compute;
                    end else begin
                        compute_cntr_q <= compute_cntr_q + 1'b1;
                    end
                end
                st_compute: begin
                    compute_cntr_q <= compute_cntr_q + 1'b1;
                    if (last_row) begin
                        state_q <= st_return;
                    end
                end
                st_return: begin
                    // results drain on their own
                    state_q <= st_stall;
                end
                default: begin
                    state_q <= st_stall;
                end
            endcase
        end
    end

    // a swap must consume a tile the loader has finished
    a_swap_needs_tile: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ctrl_o.swap_bank |-> weights_rdy_i
    );

    // never stream more rows than the instruction asked for
    a_en_within_rows: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ctrl_o.mac_en |-> (compute_cntr_q < rows_q)
    );

endmodule

`default_nettype wire

//--- source/mac_array.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module mac_array
    import tpu_pkg::*;
(
    input  wire logic                   clk_i,
    input  wire logic                   rst_n_i,
    input  wire tpu_ctrl_t              ctrl_i,
    input  wire logic                   shadow_we_i,
    input  wire logic [`TPU_IDX_W-1:0]  shadow_row_idx_i,
    input  wire tpu_vec_t               weight_row_i,
    input  wire tpu_vec_t               act_i,
    output logic                        result_valid_o,
    output tpu_acc_row_t                result_row_o
);

    localparam int N  = `TPU_MUL_SIZE;
    localparam int DW = `TPU_DATA_W;
    localparam int AW = `TPU_ACC_W;
    localparam int ND = 2 * N - 1;

    // one select bit and one swap token per diagonal
    logic [ND-1:0] sel_q;
    logic [ND-1:0] swap_sh_q;
    logic [2*N:0]  vld_q;

    logic [DW-1:0]        act_q  [N][N];
    logic signed [AW-1:0] psum_q [N][N];
    logic signed [AW-1:0] res_w  [N];

    // swap token enters at the corner and moves one diagonal per cycle
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            swap_sh_q <= '0;
            sel_q     <= '0;
        end else begin
            swap_sh_q <= {swap_sh_q[ND-2:0], ctrl_i.swap_bank};
            sel_q     <= sel_q ^ swap_sh_q;
        end
    end

    for (genvar r = 0; r < N; r++) begin : g_row
        for (genvar c = 0; c < N; c++) begin : g_col
            logic [DW-1:0]          w0_q;
            logic [DW-1:0]          w1_q;
            logic [DW-1:0]          act_in;
            logic [DW-1:0]          w_act;
            logic signed [AW-1:0]   psum_in;
            logic signed [2*DW-1:0] prod;

            assign act_in  = (c == 0) ? act_i.lane[r] : act_q[r][(c == 0) ? 0 : c-1];
            assign psum_in = (r == 0) ? '0 : psum_q[(r == 0) ? 0 : r-1][c];
            assign w_act   = sel_q[r+c] ? w1_q : w0_q;
            assign prod    = $signed(act_in) * $signed(w_act);

            // shadow write lands in the bank this cell is not reading
            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    w0_q <= '0;
                    w1_q <= '0;
                end else if (shadow_we_i && (shadow_row_idx_i == `TPU_IDX_W'(r))) begin
                    if (sel_q[r+c]) begin
                        w0_q <= weight_row_i.lane[c];
                    end else begin
                        w1_q <= weight_row_i.lane[c];
                    end
                end
            end

            always_ff @(posedge clk_i or negedge rst_n_i) begin
                if (!rst_n_i) begin
                    act_q[r][c] <= '0;
                end else begin
                    act_q[r][c] <= act_in;
                end
            end

            always_ff @(posedge clk_i) begin
                psum_q[r][c] <= psum_in + prod;
            end
        end
    end

    // column c leaves N-c cycles later so a whole row lines up
    for (genvar c = 0; c < N; c++) begin : g_deskew
        logic signed [AW-1:0] dsk_q [N-c];

        always_ff @(posedge clk_i) begin
            dsk_q[0] <= psum_q[N-1][c];
            for (int j = 1; j < N - c; j++) begin
                dsk_q[j] <= dsk_q[j-1];
            end
        end

        assign res_w[c] = dsk_q[N-c-1];
    end

    always_comb begin
        for (int c = 0; c < N; c++) begin
            result_row_o.lane[c] = res_w[c];
        end
    end

    // mac_en leads the row by one, result lands 2N after the row
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            vld_q <= '0;
        end else begin
            vld_q <= {vld_q[2*N-1:0], ctrl_i.mac_en};
        end
    end

    assign result_valid_o = vld_q[2*N];

    // no write into the bank that goes live at the corner
    a_no_write_on_swap: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        ctrl_i.swap_bank |-> !(shadow_we_i && (shadow_row_idx_i == '0))
    );

endmodule

`default_nettype wire

//--- source/tpu_compute_top.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module tpu_compute_top
    import tpu_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire logic        instr_valid_i,
    input  wire tpu_instr_u  instr_i,
    input  wire logic        weight_valid_i,
    input  wire tpu_vec_t    weight_row_i,
    input  wire tpu_vec_t    act_row_i,
    output logic             act_req_o,
    output logic             result_valid_o,
    output tpu_acc_row_t     result_row_o,
    output logic             stall_o,
    output logic             weights_ready_o
);

    tpu_ctrl_t             ctrl;
    tpu_vec_t              skewed;
    logic                  shadow_we;
    logic [`TPU_IDX_W-1:0] shadow_row_idx;
    logic                  weights_rdy;
    logic                  weights_taken;

    assign act_req_o       = ctrl.act_req;
    assign weights_ready_o = weights_rdy;

    weight_loader u_loader (
        .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .weight_valid_i,
        .weights_taken_i  (weights_taken),
        .shadow_we_o      (shadow_we),
        .shadow_row_idx_o (shadow_row_idx),
        .weights_rdy_o    (weights_rdy)
    );

    compute_control_unit u_ccu (
        .clk_i, .rst_n_i, .instr_valid_i, .instr_i,
        .weights_rdy_i   (weights_rdy),
        .ctrl_o          (ctrl),
        .weights_taken_o (weights_taken),
        .stall_o
    );

    activation_skew u_skew (
        .clk_i, .rst_n_i,
        .ctrl_i    (ctrl),
        .act_row_i,
        .skewed_o  (skewed)
    );

    mac_array u_array (
        .clk_i, .rst_n_i,
        .ctrl_i           (ctrl),
        .shadow_we_i      (shadow_we),
        .shadow_row_idx_i (shadow_row_idx),
        .weight_row_i,
        .act_i            (skewed),
        .result_valid_o,
        .result_row_o
    );

endmodule

`default_nettype wire

//--- source/tpu_defines.svh
`ifndef TPU_DEFINES_SVH
`define TPU_DEFINES_SVH

// array edge, weight rows per tile and lanes per row
`define TPU_MUL_SIZE 4

// signed activation and weight width
`define TPU_DATA_W 8

// signed partial sum width, roomy enough for a full column of products
`define TPU_ACC_W 20

// width of the row count field in a compute instruction
`define TPU_ROWS_W 8

// cycles spent loading activations before compute starts
`define TPU_ACT_WAIT 2

// weight row index width
`define TPU_IDX_W $clog2(`TPU_MUL_SIZE)

`endif

//--- source/tpu_pkg.sv
`default_nettype none

`include "tpu_defines.svh"

package tpu_pkg;

    typedef enum logic [1:0] {
        op_nop          = 2'd0,
        op_load_weights = 2'd1,
        op_compute      = 2'd2
    } tpu_op_e;

    // weight load view, tag identifies the tile
    typedef struct packed {
        tpu_op_e                 op;
        logic [1:0]              rsvd;
        logic [`TPU_ROWS_W-1:0]  tag;
    } tpu_load_instr_t;

    // compute view, rows is the number of activation rows to stream
    typedef struct packed {
        tpu_op_e                 op;
        logic [`TPU_ROWS_W-1:0]  rows;
        logic [1:0]              spare;
    } tpu_cmp_instr_t;

    typedef union packed {
        tpu_load_instr_t load;
        tpu_cmp_instr_t  cmp;
    } tpu_instr_u;

    typedef struct packed {
        logic [`TPU_MUL_SIZE-1:0][`TPU_DATA_W-1:0] lane;
    } tpu_vec_t;

    typedef struct packed {
        logic [`TPU_MUL_SIZE-1:0][`TPU_ACC_W-1:0] lane;
    } tpu_acc_row_t;

    typedef struct packed {
        logic act_req;
        logic mac_en;
        logic swap_bank;
    } tpu_ctrl_t;

endpackage

`default_nettype wire

//--- source/weight_loader.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module weight_loader
    import tpu_pkg::*;
(
    input  wire logic                  clk_i,
    input  wire logic                  rst_n_i,
    input  wire logic                  instr_valid_i,
    input  wire tpu_instr_u            instr_i,
    input  wire logic                  weight_valid_i,
    input  wire logic                  weights_taken_i,
    output logic                       shadow_we_o,
    output logic [`TPU_IDX_W-1:0]      shadow_row_idx_o,
    output logic                       weights_rdy_o
);

    logic                  armed_q;
    logic [`TPU_IDX_W-1:0] row_cnt_q;
    logic                  rdy_q;
    logic                  load_cmd;
    logic                  last_row;

    assign load_cmd = instr_valid_i && (instr_i.load.op == op_load_weights);

    // rows are written straight through, row index follows the count
    assign shadow_we_o      = weight_valid_i && armed_q;
    assign shadow_row_idx_o = row_cnt_q;
    assign last_row         = shadow_we_o && (row_cnt_q == `TPU_IDX_W'(`TPU_MUL_SIZE - 1));
    assign weights_rdy_o    = rdy_q;

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            armed_q   <= 1'b0;
            row_cnt_q <= '0;
        end else begin
            if (load_cmd) begin
                armed_q   <= 1'b1;
                row_cnt_q <= '0;
            end else if (shadow_we_o) begin
                row_cnt_q <= row_cnt_q + 1'b1;
                if (last_row) begin
                    armed_q <= 1'b0;
                end
            end
        end
    end

    // tile ready from the cycle after the last row until taken
    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            rdy_q <= 1'b0;
        end else if (last_row) begin
            rdy_q <= 1'b1;
        end else if (weights_taken_i) begin
            rdy_q <= 1'b0;
        end
    end

    // rows only come after a load_weights instruction
    a_row_needs_arm: assert property (
        @(posedge clk_i) disable iff (!rst_n_i)
        weight_valid_i |-> armed_q
    );

endmodule

`default_nettype wire

//--- verif/tpu_compute_tb.sv
`timescale 1ns/100ps
`default_nettype none

`include "tpu_defines.svh"

module tpu_compute_tb
    import tpu_pkg::*;
();

    localparam int N           = `TPU_MUL_SIZE;
    localparam int DW          = `TPU_DATA_W;
    localparam int WAIT_LIMIT  = 400;
    localparam int NUM_ENTRIES = 7;

    localparam logic [1:0] TILE_RAND = 2'd0;
    localparam logic [1:0] TILE_KEEP = 2'd1;
    localparam logic [1:0] TILE_MAX  = 2'd2;
    localparam logic [1:0] TILE_MIN  = 2'd3;

    localparam int PROBE_READY   = 0;
    localparam int PROBE_STALL   = 1;
    localparam int PROBE_DRAINED = 2;

    // one compute job with its tile source, row count, activation style and ordering
    typedef struct packed {
        logic [1:0]             tile;
        logic [`TPU_ROWS_W-1:0] rows;
        logic                   extreme;
        logic                   cmd_first;
        logic                   overlap;
    } entry_t;

    logic         clk_i;
    logic         rst_n_i;
    logic         instr_valid_i;
    tpu_instr_u   instr_i;
    logic         weight_valid_i;
    tpu_vec_t     weight_row_i;
    tpu_vec_t     act_row_i;
    logic         act_req_o;
    logic         result_valid_o;
    tpu_acc_row_t result_row_o;
    logic         stall_o;
    logic         weights_ready_o;

    integer       seed;
    entry_t       stim_table [NUM_ENTRIES];
    tpu_vec_t     entry_tile [N];
    tpu_vec_t     next_tile  [N];
    tpu_vec_t     act_q      [$];
    tpu_acc_row_t expected_q [$];
    int           tile_tag;
    logic         preloaded;

    tpu_compute_top dut_i (
        .clk_i, .rst_n_i, .instr_valid_i, .instr_i, .weight_valid_i, .weight_row_i,
        .act_row_i, .act_req_o, .result_valid_o, .result_row_o, .stall_o, .weights_ready_o
    );

    initial begin
        clk_i = 1'b0;
        forever #4 clk_i = ~clk_i;
    end

    task automatic stop_run();
        $display("test failed");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic check_result(input tpu_acc_row_t exp);
        if (result_row_o !== exp) begin
            $display("mismatch result_row_o: got %h expected %h", result_row_o, exp);
            stop_run();
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string name);
        if (got !== exp) begin
            $display("mismatch %s: got %h expected %h", name, got, exp);
            stop_run();
        end
    endtask

    function automatic logic probe(input int sel);
        case (sel)
            PROBE_READY: return weights_ready_o;
            PROBE_STALL: return stall_o;
            default:     return (expected_q.size() == 0);
        endcase
    endfunction

    task automatic wait_level(input int sel, input logic level, input string what);
        int cnt;
        cnt = 0;
        while (probe(sel) !== level) begin
            @(posedge clk_i);
            cnt++;
            if (cnt > WAIT_LIMIT) begin
                $display("timeout while waiting for %s", what);
                stop_run();
            end
        end
    endtask

    // signed row vector times the tile
    function automatic tpu_acc_row_t row_times_tile(input tpu_vec_t a);
        tpu_acc_row_t                 res;
        logic signed [`TPU_ACC_W-1:0] sum;
        for (int c = 0; c < N; c++) begin
            sum = '0;
            for (int r = 0; r < N; r++) begin
                sum = sum + $signed(a.lane[r]) * $signed(entry_tile[r].lane[c]);
            end
            res.lane[c] = sum;
        end
        return res;
    endfunction

    task automatic build_tile(input logic [1:0] kind);
        for (int r = 0; r < N; r++) begin
            for (int c = 0; c < N; c++) begin
                case (kind)
                    TILE_KEEP: next_tile[r].lane[c] = entry_tile[r].lane[c];
                    TILE_MAX:  next_tile[r].lane[c] = 8'h7f;
                    TILE_MIN:  next_tile[r].lane[c] = 8'h80;
                    default:   next_tile[r].lane[c] = DW'($random(seed));
                endcase
            end
        end
    endtask

    task automatic load_tile();
        tpu_instr_u ins;
        ins          = '0;
        ins.load.op  = op_load_weights;
        ins.load.tag = `TPU_ROWS_W'(tile_tag);
        tile_tag++;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        for (int r = 0; r < N; r++) begin
            @(posedge clk_i);
            instr_valid_i  <= 1'b0;
            weight_valid_i <= 1'b1;
            weight_row_i   <= next_tile[r];
        end
        @(posedge clk_i);
        weight_valid_i <= 1'b0;
        wait_level(PROBE_READY, 1'b1, "weights_ready_o to rise after a tile load");
    endtask

    task automatic queue_rows(input int rows, input logic extreme);
        tpu_vec_t a;
        for (int i = 0; i < rows; i++) begin
            for (int k = 0; k < N; k++) begin
                if (extreme) begin
                    a.lane[k] = (i % 2 == 0) ? 8'h80 : 8'h7f;
                end else begin
                    a.lane[k] = DW'($random(seed));
                end
            end
            act_q.push_back(a);
            expected_q.push_back(row_times_tile(a));
        end
    endtask

    task automatic issue_compute(input logic [`TPU_ROWS_W-1:0] rows);
        tpu_instr_u ins;
        ins          = '0;
        ins.cmp.op   = op_compute;
        ins.cmp.rows = rows;
        @(posedge clk_i);
        instr_valid_i <= 1'b1;
        instr_i       <= ins;
        @(posedge clk_i);
        instr_valid_i <= 1'b0;
    endtask

    task automatic hold_stalled(input int cycles);
        repeat (cycles) begin
            @(posedge clk_i);
            check_flag(stall_o, 1'b1, "stall_o");
            check_flag(result_valid_o, 1'b0, "result_valid_o");
        end
    endtask

    task automatic run_entry(input int i);
        entry_t e;
        e = stim_table[i];
        if (!preloaded) begin
            build_tile(e.tile);
            if (!e.cmd_first) begin
                load_tile();
            end
        end
        preloaded = 1'b0;
        for (int r = 0; r < N; r++) begin
            entry_tile[r] = next_tile[r];
        end
        if (e.cmd_first) begin
            wait_level(PROBE_DRAINED, 1'b1, "earlier results to drain");
        end
        queue_rows(e.rows, e.extreme);
        issue_compute(e.rows);
        if (e.cmd_first) begin
            hold_stalled(12);
            load_tile();
        end
        wait_level(PROBE_READY, 1'b0, "the tile to be taken by a bank swap");
        if (e.overlap && (i + 1 < NUM_ENTRIES)) begin
            // swap wavefront must clear every diagonal before new shadow writes
            repeat (2 * N + 2) @(posedge clk_i);
            build_tile(stim_table[i+1].tile);
            load_tile();
            preloaded = 1'b1;
        end else begin
            wait_level(PROBE_STALL, 1'b1, "the compute to finish");
        end
    endtask

    // next activation row goes out the cycle after each request
    always @(posedge clk_i) begin
        if (act_req_o) begin
            if (act_q.size() == 0) begin
                $display("act_req_o was high with no activation row left to send");
                stop_run();
            end else begin
                act_row_i <= act_q.pop_front();
            end
        end
    end

    always @(posedge clk_i) begin
        if (result_valid_o) begin
            if (expected_q.size() == 0) begin
                $display("result_valid_o was high with no result row expected");
                stop_run();
            end else begin
                check_result(expected_q.pop_front());
            end
        end
    end

    initial begin
        seed           = 32'h35c6;
        rst_n_i        = 1'b0;
        instr_valid_i  = 1'b0;
        instr_i        = '0;
        weight_valid_i = 1'b0;
        weight_row_i   = '0;
        act_row_i      = '0;
        tile_tag       = 0;
        preloaded      = 1'b0;
        for (int r = 0; r < N; r++) begin
            entry_tile[r] = '0;
            next_tile[r]  = '0;
        end
        // tile, rows, extreme, cmd_first, overlap
        stim_table[0] = '{TILE_RAND, 8'd3,  1'b0, 1'b0, 1'b0};
        stim_table[1] = '{TILE_RAND, 8'd20, 1'b0, 1'b0, 1'b1};
        stim_table[2] = '{TILE_RAND, 8'd6,  1'b0, 1'b0, 1'b1};
        stim_table[3] = '{TILE_KEEP, 8'd5,  1'b0, 1'b0, 1'b0};
        stim_table[4] = '{TILE_RAND, 8'd4,  1'b0, 1'b1, 1'b0};
        stim_table[5] = '{TILE_MAX,  8'd40, 1'b1, 1'b0, 1'b1};
        stim_table[6] = '{TILE_MIN,  8'd40, 1'b1, 1'b0, 1'b0};
        repeat (2) @(posedge clk_i);
        rst_n_i <= 1'b1;
        @(posedge clk_i);
        check_flag(result_valid_o, 1'b0, "result_valid_o");
        check_flag(stall_o, 1'b1, "stall_o");
        check_flag(weights_ready_o, 1'b0, "weights_ready_o");
        for (int i = 0; i < NUM_ENTRIES; i++) begin
            run_entry(i);
        end
        wait_level(PROBE_DRAINED, 1'b1, "the last result rows");
        // any extra valid row shows up here
        repeat (2 * N + 2) @(posedge clk_i);
        $display("test passed");
        $finish;
    end

endmodule

`default_nettype wire
